/* common/serial_pkg.sv */
package serial_pkg;

   // ************************************************
   // serial word geometry
   // ************************************************

   // width of every wide CSR and of every serial word
   localparam int XLEN = 32;

   localparam int CNT_W = $clog2(XLEN);

   // number of the bit in flight, LSB first
   typedef logic [CNT_W-1:0] bit_cnt_t;

   // first and last bit of a word
   localparam bit_cnt_t CNT_FIRST = '0;
   localparam bit_cnt_t CNT_LAST  = bit_cnt_t'(XLEN - 1);

endpackage

/* common/csr_pkg.sv */
package csr_pkg;

   import serial_pkg::*;

   // machine-mode CSRs handled by the serial file
   typedef enum logic [11:0] {
      addr_mstatus  = 12'h300,
      addr_mie      = 12'h304,
      addr_mtvec    = 12'h305,
      addr_mscratch = 12'h340,
      addr_mepc     = 12'h341,
      addr_mcause   = 12'h342,
      addr_mtval    = 12'h343,
      addr_mip      = 12'h344
   } csr_addr_e;

   typedef enum logic [1:0] {
      op_write = 2'd0,
      op_set   = 2'd1,
      op_clr   = 2'd2,
      op_read  = 2'd3
   } csr_op_e;

   // one queued access or trap
   typedef struct packed {
      logic            is_trap;
      csr_addr_e       addr;
      csr_op_e         op;
      logic [XLEN-1:0] wdata;
      logic [XLEN-1:0] pc;
      logic [XLEN-1:0] tval;
      logic [3:0]      cause;
   } csr_cmd_t;

   // position of each CSR in the one-hot select
   localparam int N_CSR        = 8;
   localparam int SEL_MSTATUS  = 0;
   localparam int SEL_MIE      = 1;
   localparam int SEL_MTVEC    = 2;
   localparam int SEL_MSCRATCH = 3;
   localparam int SEL_MEPC     = 4;
   localparam int SEL_MCAUSE   = 5;
   localparam int SEL_MTVAL    = 6;
   localparam int SEL_MIP      = 7;

   // live bits of the narrow CSRs
   localparam int MSTATUS_MIE_BIT = 3;
   localparam int MIE_MTIE_BIT    = 7;
   localparam int MIP_MTIP_BIT    = 7;

   // machine timer interrupt
   localparam logic [3:0] IRQ_CAUSE = 4'd7;

endpackage

/* common/csr_serial_if.sv */
`timescale 1ns/1ps

interface csr_serial_if import csr_pkg::*, serial_pkg::*; ();

   bit_cnt_t         cnt;
   logic             busy;
   logic [N_CSR-1:0] sel;
   csr_op_e          op;
   logic             d;
   logic             trap;
   logic             trap_pc;
   logic             trap_tval;
   logic [3:0]       trap_cause;
   logic             q;
   // high during cnt 31 only
   logic             last;

   modport sequencer (
      output cnt, busy, sel, op, d,
      output trap, trap_pc, trap_tval, trap_cause,
      output last
   );

   modport file (
      input  cnt, sel, op, d,
      input  trap, trap_pc, trap_tval, trap_cause,
      output q
   );

   // trap needed to suppress the result of a trap command
   modport collector (
      input q, busy, last, trap
   );

endinterface

/* hw/csr_cmd_fifo.sv */
`timescale 1ns/1ps

module csr_cmd_fifo import csr_pkg::*; #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic     i_clk,
   input  logic     i_arst_n,
   input  logic     i_push,
   input  csr_cmd_t i_cmd,
   input  logic     i_pop,
   output csr_cmd_t o_head,
   output logic     o_empty,
   output logic     o_full
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int OCC_W = PTR_W + 1;

   csr_cmd_t         mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [OCC_W-1:0] count;
   logic [OCC_W-1:0] count_next;
   logic             do_push;
   logic             do_pop;

   // wraps at any depth, not only powers of two
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign do_push    = i_push && !o_full;
   assign do_pop     = i_pop && !o_empty;
   assign count_next = count + OCC_W'(do_push) - OCC_W'(do_pop);

   assign o_head = mem[rd_ptr];

   always_ff @(posedge i_clk) begin
      if (do_push)
         mem[wr_ptr] <= i_cmd;
   end

   // pointers, occupancy and the registered flags
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
         o_empty <= 1'b1;
         o_full  <= 1'b0;
      end else begin
         if (do_push)
            wr_ptr <= ptr_inc(wr_ptr);
         if (do_pop)
            rd_ptr <= ptr_inc(rd_ptr);
         count   <= count_next;
         o_empty <= (count_next == '0);
         o_full  <= (count_next == OCC_W'(FIFO_DEPTH));
      end
   end

   // ************************************************
   // protocol checks
   // ************************************************

   // sender has to respect o_cmd_full at the top
   a_no_push_full: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      i_push |-> !o_full);

   a_no_pop_empty: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      i_pop |-> !o_empty);

endmodule

/* csr/csr_sequencer.sv */
`timescale 1ns/1ps

module csr_sequencer import csr_pkg::*, serial_pkg::*; (
   input  logic           i_clk,
   input  logic           i_arst_n,
   input  csr_cmd_t       i_head,
   input  logic           i_empty,
   output logic           o_pop,
   csr_serial_if.sequencer bus
);

   logic             busy_r;
   bit_cnt_t         cnt_r;
   logic [N_CSR-1:0] sel_r;
   logic             trap_r;
   csr_op_e          op_r;
   logic [3:0]       cause_r;
   logic [XLEN-1:0]  wdata_sr;
   logic [XLEN-1:0]  pc_sr;
   logic [XLEN-1:0]  tval_sr;

   // unknown address selects nothing
   function automatic logic [N_CSR-1:0] decode_sel(input csr_addr_e addr);
      logic [N_CSR-1:0] sel;
      sel = '0;
      case (addr)
         addr_mstatus:  sel[SEL_MSTATUS]  = 1'b1;
         addr_mie:      sel[SEL_MIE]      = 1'b1;
         addr_mtvec:    sel[SEL_MTVEC]    = 1'b1;
         addr_mscratch: sel[SEL_MSCRATCH] = 1'b1;
         addr_mepc:     sel[SEL_MEPC]     = 1'b1;
         addr_mcause:   sel[SEL_MCAUSE]   = 1'b1;
         addr_mtval:    sel[SEL_MTVAL]    = 1'b1;
         addr_mip:      sel[SEL_MIP]      = 1'b1;
         default: ;
      endcase
      return sel;
   endfunction

   // one idle cycle always sits between two commands
   assign o_pop = !busy_r && !i_empty;

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         busy_r <= 1'b0;
         cnt_r  <= CNT_FIRST;
         sel_r  <= '0;
         trap_r <= 1'b0;
      end else if (o_pop) begin
         busy_r <= 1'b1;
         cnt_r  <= CNT_FIRST;
         sel_r  <= i_head.is_trap ? '0 : decode_sel(i_head.addr);
         trap_r <= i_head.is_trap;
      end else if (busy_r) begin
         cnt_r <= cnt_r + 1'b1;
         if (cnt_r == CNT_LAST) begin
            busy_r <= 1'b0;
            sel_r  <= '0;
            trap_r <= 1'b0;
         end
      end
   end

   // payload shifted out LSB first
   always_ff @(posedge i_clk) begin
      if (o_pop) begin
         op_r     <= i_head.op;
         cause_r  <= i_head.cause;
         wdata_sr <= i_head.wdata;
         pc_sr    <= i_head.pc;
         tval_sr  <= i_head.tval;
      end else if (busy_r) begin
         wdata_sr <= wdata_sr >> 1;
         pc_sr    <= pc_sr >> 1;
         tval_sr  <= tval_sr >> 1;
      end
   end

   assign bus.cnt        = cnt_r;
   assign bus.busy       = busy_r;
   assign bus.sel        = sel_r;
   assign bus.op         = op_r;
   assign bus.d          = wdata_sr[0];
   assign bus.trap       = trap_r;
   assign bus.trap_pc    = pc_sr[0];
   assign bus.trap_tval  = tval_sr[0];
   assign bus.trap_cause = cause_r;
   assign bus.last       = busy_r && (cnt_r == CNT_LAST);

   a_sel_onehot: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      $onehot0(bus.sel));

endmodule

/* csr/csr_file.sv */
`timescale 1ns/1ps

module csr_file import csr_pkg::*, serial_pkg::*; (
   input  logic       i_clk,
   input  logic       i_arst_n,
   input  logic       i_mtip,
   output logic       o_timer_irq_en,
   csr_serial_if.file bus
);

   logic             mstatus_mie;
   logic             mie_mtie;
   logic [XLEN-1:0]  mtvec;
   logic [XLEN-1:0]  mscratch;
   logic [XLEN-1:0]  mepc;
   logic [XLEN-1:0]  mcause;
   logic [XLEN-1:0]  mtval;
   logic [N_CSR-1:0] rd_bits;
   logic             csr_old;
   logic             csr_new;
   logic             first_bit;
   logic             irq_now;
   logic             irq_hold;
   logic             irq_trap;
   logic [XLEN-1:0]  cause_word;
   logic             cause_bit;

   assign o_timer_irq_en = mstatus_mie & mie_mtie;
   assign irq_now        = i_mtip & o_timer_irq_en;
   assign first_bit      = (bus.cnt == CNT_FIRST);

   // ************************************************
   // read path
   // ************************************************

   // wide CSRs rotate, so bit n sits at [0] during cnt n
   always_comb begin
      rd_bits[SEL_MSTATUS]  = mstatus_mie & (bus.cnt == bit_cnt_t'(MSTATUS_MIE_BIT));
      rd_bits[SEL_MIE]      = mie_mtie & (bus.cnt == bit_cnt_t'(MIE_MTIE_BIT));
      rd_bits[SEL_MIP]      = irq_now & (bus.cnt == bit_cnt_t'(MIP_MTIP_BIT));
      rd_bits[SEL_MTVEC]    = mtvec[0];
      rd_bits[SEL_MSCRATCH] = mscratch[0];
      rd_bits[SEL_MEPC]     = mepc[0];
      rd_bits[SEL_MCAUSE]   = mcause[0];
      rd_bits[SEL_MTVAL]    = mtval[0];
   end

   assign csr_old = |(bus.sel & rd_bits);
   assign bus.q   = csr_old;

   always_comb begin
      case (bus.op)
         op_write: csr_new = bus.d;
         op_set:   csr_new = csr_old | bus.d;
         op_clr:   csr_new = csr_old & ~bus.d;
         default:  csr_new = csr_old;
      endcase
   end

   // interrupt decision taken at the first trap bit
   assign irq_trap   = first_bit ? irq_now : irq_hold;
   assign cause_word = irq_trap ? {1'b1, {(XLEN - 5){1'b0}}, IRQ_CAUSE}
                                : {{(XLEN - 4){1'b0}}, bus.trap_cause};
   assign cause_bit  = cause_word[bus.cnt];

   // ************************************************
   // register update
   // ************************************************

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         mstatus_mie <= 1'b0;
         mie_mtie    <= 1'b0;
         irq_hold    <= 1'b0;
         mtvec       <= '0;
         mscratch    <= '0;
         mepc        <= '0;
         mcause      <= '0;
         mtval       <= '0;
      end else begin
         // narrow CSRs take only their live bit
         if (bus.sel[SEL_MSTATUS] && bus.cnt == bit_cnt_t'(MSTATUS_MIE_BIT))
            mstatus_mie <= csr_new;
         if (bus.sel[SEL_MIE] && bus.cnt == bit_cnt_t'(MIE_MTIE_BIT))
            mie_mtie <= csr_new;

         if (bus.trap && first_bit)
            irq_hold <= irq_now;

         if (bus.sel[SEL_MTVEC])
            mtvec <= {csr_new, mtvec[XLEN-1:1]};
         if (bus.sel[SEL_MSCRATCH])
            mscratch <= {csr_new, mscratch[XLEN-1:1]};

         // trap fields shift in over the same 32 cycles
         if (bus.sel[SEL_MEPC] || bus.trap)
            mepc <= {bus.trap ? bus.trap_pc : csr_new, mepc[XLEN-1:1]};
         if (bus.sel[SEL_MCAUSE] || bus.trap)
            mcause <= {bus.trap ? cause_bit : csr_new, mcause[XLEN-1:1]};
         if (bus.sel[SEL_MTVAL] || bus.trap)
            mtval <= {bus.trap ? bus.trap_tval : csr_new, mtval[XLEN-1:1]};
      end
   end

   // sequencer never enables a CSR while a trap is recorded
   a_trap_no_sel: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      bus.trap |-> (bus.sel == '0));

endmodule

/* hw/csr_read_collector.sv */
`timescale 1ns/1ps

module csr_read_collector import serial_pkg::*; (
   input  logic            i_clk,
   input  logic            i_arst_n,
   csr_serial_if.collector bus,
   output logic [XLEN-1:0] o_rdata,
   output logic            o_rvalid
);

   // ************************************************
   // serial to parallel
   // ************************************************

   // q enters at the top so bit 0 ends up at [0] after 32 shifts
   always_ff @(posedge i_clk) begin
      if (bus.busy)
         o_rdata <= {bus.q, o_rdata[XLEN-1:1]};
   end

   // no result pulse for a trap
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n)
         o_rvalid <= 1'b0;
      else
         o_rvalid <= bus.last && !bus.trap;
   end

   // commands are at least 33 cycles apart
   a_rvalid_pulse: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      o_rvalid |=> !o_rvalid);

endmodule

/* hw/csr_top.sv */
`timescale 1ns/1ps

module csr_top import csr_pkg::*, serial_pkg::*; #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic            i_clk,
   input  logic            i_arst_n,
   input  logic            i_cmd_valid,
   input  csr_cmd_t        i_cmd,
   output logic            o_cmd_full,
   input  logic            i_mtip,
   output logic            o_timer_irq_en,
   output logic [XLEN-1:0] o_rdata,
   output logic            o_rvalid
);

   csr_cmd_t head;
   logic     fifo_empty;
   logic     pop;

   // bit stream shared by the three serial blocks
   csr_serial_if bus ();

   csr_cmd_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_cmd_fifo (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_push   (i_cmd_valid),
      .i_cmd    (i_cmd),
      .i_pop    (pop),
      .o_head   (head),
      .o_empty  (fifo_empty),
      .o_full   (o_cmd_full)
   );

   csr_sequencer u_sequencer (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_head   (head),
      .i_empty  (fifo_empty),
      .o_pop    (pop),
      .bus      (bus.sequencer)
   );

   csr_file u_csr_file (
      .i_clk          (i_clk),
      .i_arst_n       (i_arst_n),
      .i_mtip         (i_mtip),
      .o_timer_irq_en (o_timer_irq_en),
      .bus            (bus.file)
   );

   csr_read_collector u_collector (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .bus      (bus.collector),
      .o_rdata  (o_rdata),
      .o_rvalid (o_rvalid)
   );

endmodule

/* tests/tb_csr_top.sv */
`timescale 1ns/1ps

module tb_csr_top import csr_pkg::*, serial_pkg::*; ();

   localparam int FIFO_DEPTH  = 4;
   localparam int N_RW        = 20;
   localparam int N_SETCLR    = 8;
   localparam int N_NARROW    = 6;
   localparam int N_IRQ       = 6;
   localparam int N_TRAP      = 8;
   localparam int N_BURST     = 12;
   localparam int N_CMDS      = N_RW + N_SETCLR + N_NARROW + N_IRQ + N_TRAP + N_BURST;
   localparam int CYCLE_LIMIT = N_CMDS * 34 + 200;
   localparam logic [15:0] LFSR_TAPS = 16'hB400;

   logic            i_clk = 1'b0;
   logic            i_arst_n;
   logic            i_cmd_valid;
   csr_cmd_t        i_cmd;
   logic            o_cmd_full;
   logic            i_mtip;
   logic            o_timer_irq_en;
   logic [XLEN-1:0] o_rdata;
   logic            o_rvalid;

   // reference model with the wide CSRs in the order mtvec mscratch mepc mcause mtval
   logic            m_mie;
   logic            m_mtie;
   logic [XLEN-1:0] m_wide [5];
   logic [XLEN-1:0] exp_q [$];
   logic [XLEN-1:0] exp_head;
   int              exp_cnt;
   int              full_cycles;
   int              cycles;
   logic [15:0]     lfsr_state = 16'd62531;

   csr_top #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) uut (
      .i_clk          (i_clk),
      .i_arst_n       (i_arst_n),
      .i_cmd_valid    (i_cmd_valid),
      .i_cmd          (i_cmd),
      .o_cmd_full     (o_cmd_full),
      .i_mtip         (i_mtip),
      .o_timer_irq_en (o_timer_irq_en),
      .o_rdata        (o_rdata),
      .o_rvalid       (o_rvalid)
   );

   always #2 i_clk = ~i_clk;

   // ************************************************
   // failure reporting
   // ************************************************

   task automatic abort_run();
      $display("CHECKS FAILED");
      $fatal(1);
   endtask

   task automatic show_mismatch(input string name, input logic [XLEN-1:0] exp,
                                input logic [XLEN-1:0] act);
      $display("ERR %0t %s expected %08h actual %08h", $time, name, exp, act);
      abort_run();
   endtask

   task automatic explain_failure(input string msg);
      $display("%s at %0t", msg, $time);
      abort_run();
   endtask

   // ************************************************
   // random data and the reference model
   // ************************************************

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
   endfunction

   task automatic rand_bits(input int nbits, output logic [XLEN-1:0] val);
      val = '0;
      for (int i = 0; i < nbits; i++) begin
         val        = {val[XLEN-2:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   function automatic csr_addr_e any_csr(input int i);
      case (i)
         0:       return addr_mtvec;
         1:       return addr_mscratch;
         2:       return addr_mepc;
         3:       return addr_mcause;
         4:       return addr_mtval;
         5:       return addr_mstatus;
         6:       return addr_mie;
         default: return addr_mip;
      endcase
   endfunction

   function automatic logic [XLEN-1:0] model_value(input csr_addr_e addr);
      logic [XLEN-1:0] v;
      v = '0;
      case (addr)
         addr_mstatus:  v[MSTATUS_MIE_BIT] = m_mie;
         addr_mie:      v[MIE_MTIE_BIT] = m_mtie;
         addr_mip:      v[MIP_MTIP_BIT] = i_mtip & m_mie & m_mtie;
         addr_mtvec:    v = m_wide[0];
         addr_mscratch: v = m_wide[1];
         addr_mepc:     v = m_wide[2];
         addr_mcause:   v = m_wide[3];
         addr_mtval:    v = m_wide[4];
         default: ;
      endcase
      return v;
   endfunction

   // every command takes effect here in issue order
   task automatic apply_model(input csr_cmd_t cmd);
      logic [XLEN-1:0] old_val;
      logic [XLEN-1:0] new_val;
      if (cmd.is_trap) begin
         m_wide[2] = cmd.pc;
         m_wide[4] = cmd.tval;
         if (i_mtip && m_mie && m_mtie)
            m_wide[3] = {1'b1, 31'(IRQ_CAUSE)};
         else
            m_wide[3] = XLEN'(cmd.cause);
      end else begin
         old_val = model_value(cmd.addr);
         case (cmd.op)
            op_write: new_val = cmd.wdata;
            op_set:   new_val = old_val | cmd.wdata;
            op_clr:   new_val = old_val & ~cmd.wdata;
            default:  new_val = old_val;
         endcase
         case (cmd.addr)
            addr_mstatus:  m_mie = new_val[MSTATUS_MIE_BIT];
            addr_mie:      m_mtie = new_val[MIE_MTIE_BIT];
            addr_mtvec:    m_wide[0] = new_val;
            addr_mscratch: m_wide[1] = new_val;
            addr_mepc:     m_wide[2] = new_val;
            addr_mcause:   m_wide[3] = new_val;
            addr_mtval:    m_wide[4] = new_val;
            default: ;
         endcase
         exp_q.push_back(old_val);
      end
   endtask

   // ************************************************
   // stimulus
   // ************************************************

   // at most one strobe every other cycle, so full at the negedge is current
   task automatic issue(input csr_cmd_t cmd);
      @(negedge i_clk);
      while (o_cmd_full)
         @(negedge i_clk);
      @(posedge i_clk);
      i_cmd_valid <= 1'b1;
      i_cmd       <= cmd;
      apply_model(cmd);
      @(posedge i_clk);
      i_cmd_valid <= 1'b0;
   endtask

   task automatic csr_access(input csr_addr_e addr, input csr_op_e op,
                             input logic [XLEN-1:0] data);
      csr_cmd_t cmd;
      cmd       = '0;
      cmd.addr  = addr;
      cmd.op    = op;
      cmd.wdata = data;
      issue(cmd);
   endtask

   task automatic trap_entry(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] tval,
                             input logic [3:0] cause);
      csr_cmd_t cmd;
      cmd         = '0;
      cmd.is_trap = 1'b1;
      cmd.pc      = pc;
      cmd.tval    = tval;
      cmd.cause   = cause;
      issue(cmd);
   endtask

   // last command before a drain is never a trap
   task automatic drain_results();
      do
         @(negedge i_clk);
      while (exp_cnt != 0);
   endtask

   task automatic check_irq_en();
      assert (o_timer_irq_en == (m_mie & m_mtie))
         else show_mismatch("o_timer_irq_en", XLEN'(m_mie & m_mtie), XLEN'(o_timer_irq_en));
   endtask

   // ************************************************
   // result tracking and checks
   // ************************************************

   always @(posedge i_clk) begin
      if (o_rvalid && exp_q.size() != 0)
         exp_q.delete(0);
      exp_cnt  = exp_q.size();
      exp_head = (exp_cnt != 0) ? exp_q[0] : '0;
   end

   always @(negedge i_clk) begin
      if (o_cmd_full === 1'b1)
         full_cycles++;
   end

   always @(posedge i_clk) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT)
         explain_failure("timeout, results stopped arriving");
   end

   a_rdata: assert property (@(negedge i_clk) disable iff (!i_arst_n)
      o_rvalid |-> (o_rdata == exp_head))
      else show_mismatch("o_rdata", exp_head, o_rdata);

   a_result_pending: assert property (@(negedge i_clk) disable iff (!i_arst_n)
      o_rvalid |-> (exp_cnt != 0))
      else explain_failure("o_rvalid pulsed with no command pending");

   a_strobe_not_full: assert property (@(negedge i_clk) disable iff (!i_arst_n)
      i_cmd_valid |-> !o_cmd_full)
      else explain_failure("command strobed while the FIFO was full");

   initial begin : main
      logic [XLEN-1:0] r;
      logic [XLEN-1:0] pc;
      logic [XLEN-1:0] tval;
      int              full_before;
      i_arst_n    = 1'b0;
      i_cmd_valid = 1'b0;
      i_cmd       = '0;
      i_mtip      = 1'b0;
      m_mie       = 1'b0;
      m_mtie      = 1'b0;
      for (int i = 0; i < 5; i++)
         m_wide[i] = '0;
      repeat (4) @(posedge i_clk);
      i_arst_n <= 1'b1;
      @(negedge i_clk);
      assert (!o_rvalid && !o_cmd_full && !o_timer_irq_en)
         else explain_failure("outputs not at their reset values");

      // wide CSRs written then read back
      for (int i = 0; i < N_RW / 2; i++) begin
         rand_bits(XLEN, r);
         csr_access(any_csr(i % 5), op_write, r);
         csr_access(any_csr(i % 5), op_read, '0);
      end
      for (int i = 0; i < N_SETCLR / 4; i++) begin
         rand_bits(XLEN, r);
         csr_access(any_csr(i), op_set, r);
         csr_access(any_csr(i), op_read, '0);
         rand_bits(XLEN, r);
         csr_access(any_csr(i), op_clr, r);
         csr_access(any_csr(i), op_read, '0);
      end

      // narrow CSRs keep only the live bit
      csr_access(addr_mstatus, op_write, '1);
      csr_access(addr_mstatus, op_read, '0);
      csr_access(addr_mie, op_write, '1);
      csr_access(addr_mie, op_read, '0);
      csr_access(addr_mip, op_write, '1);
      csr_access(addr_mip, op_read, '0);
      drain_results();
      check_irq_en();

      // pending timer interrupt
      @(posedge i_clk);
      i_mtip <= 1'b1;
      csr_access(addr_mip, op_read, '0);
      csr_access(addr_mstatus, op_clr, 32'h8);
      csr_access(addr_mip, op_read, '0);
      csr_access(addr_mie, op_read, '0);
      drain_results();
      check_irq_en();
      csr_access(addr_mstatus, op_set, 32'h8);
      csr_access(addr_mstatus, op_read, '0);
      drain_results();
      check_irq_en();

      // traps with the interrupt taken first
      for (int t = 0; t < N_TRAP / 4; t++) begin
         rand_bits(XLEN, pc);
         rand_bits(XLEN, tval);
         rand_bits(4, r);
         trap_entry(pc, tval, r[3:0]);
         csr_access(addr_mepc, op_read, '0);
         csr_access(addr_mtval, op_read, '0);
         csr_access(addr_mcause, op_read, '0);
         drain_results();
         @(posedge i_clk);
         i_mtip <= 1'b0;
      end

      // burst that fills the FIFO
      full_before = full_cycles;
      for (int i = 0; i < N_BURST; i++) begin
         rand_bits(3, r);
         rand_bits(2, pc);
         rand_bits(XLEN, tval);
         csr_access(any_csr(int'(r[2:0])), csr_op_e'(pc[1:0]), tval);
      end
      drain_results();
      check_irq_en();
      assert (full_cycles > full_before)
         else explain_failure("o_cmd_full never rose during the burst");

      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

/* all.f */
common/serial_pkg.sv
common/csr_pkg.sv
common/csr_serial_if.sv
hw/csr_cmd_fifo.sv
csr/csr_sequencer.sv
csr/csr_file.sv
hw/csr_read_collector.sv
hw/csr_top.sv
tests/tb_csr_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_csr_top
FILELIST  := all.f
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
PASS_MSG  := ALL CHECKS PASSED

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
